/* uarc_intc.f */
hw/uarc_cfg_pkg.sv
hw/uarc_isa_pkg.sv
hw/uarc_cmd_decode.sv
hw/uarc_bus_slot.sv
hw/uarc_irq_arbiter.sv
hw/uarc_intc.sv
test/uarc_intc_asserts.sv
test/uarc_intc_tb.sv

/* Bender.yml */
package:
  name: uarc_intc

sources:
  - hw/uarc_cfg_pkg.sv
  - hw/uarc_isa_pkg.sv
  - hw/uarc_cmd_decode.sv
  - hw/uarc_bus_slot.sv
  - hw/uarc_irq_arbiter.sv
  - hw/uarc_intc.sv
  - target: test
    files:
      - test/uarc_intc_asserts.sv
      - test/uarc_intc_tb.sv

/* test/uarc_intc_tb.sv */
`timescale 1ns/1ps

module uarc_intc_tb;
  import uarc_cfg_pkg::*;
  import uarc_isa_pkg::*;

  localparam int WAIT_LIMIT    = 50;
  localparam int SETTLE_CYCLES = 4;

  typedef enum logic [1:0] {EXP_NONE, EXP_IRQ, EXP_RECV} exp_kind_e;

  // One row of the stimulus table
  typedef struct packed {
    uarc_op_e   op;
    bus_idx_t   bus;
    prog_addr_t addr;
    bus_vec_t   enables;
    bus_vec_t   raise;
    exp_kind_e  kind;
    bus_idx_t   exp_bus;
    prog_addr_t exp_addr;
  } row_t;

  // One delivery pulse as seen on the outputs
  typedef struct packed {
    exp_kind_e  kind;
    bus_idx_t   bus;
    prog_addr_t addr;
    word_t      value;
    bus_vec_t   acks;
    int         cycle;
  } delivery_t;

  logic                       clk;
  logic                       rst;
  logic                       cmd_valid;
  uarc_op_e                   cmd_op;
  bus_idx_t                   cmd_bus;
  prog_addr_t                 cmd_addr;
  bus_vec_t                   receiver_enables;
  bus_vec_t                   receiver_sends;
  word_t [BUS_COUNT-1:0]      receiver_datas;
  logic                       cmd_ready;
  bus_vec_t                   sender_enables;
  bus_vec_t                   receiver_send_acks;
  logic                       irq_valid;
  bus_idx_t                   irq_bus;
  prog_addr_t                 irq_address;
  word_t                      irq_value;
  logic                       recv_valid;
  bus_idx_t                   recv_bus;
  word_t                      recv_value;
  logic                       interrupt_active;

  row_t        stim_rows[$];
  delivery_t   seen[$];
  word_t       data_model [BUS_COUNT];
  bus_vec_t    sel_model;
  logic        active_model;
  bus_vec_t    raise_pending;
  logic [15:0] lfsr_state;
  int          cycle_no;
  int          raise_cycle;
  logic        s_ready;
  logic        s_active;
  logic        s_irq_valid;
  logic        s_recv_valid;
  bus_vec_t    s_enables;
  bus_vec_t    s_acks;

  uarc_intc dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_word(output word_t w);
    w = '0;
    for (int b = 0; b < WORD_WIDTH; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[WORD_WIDTH-2:0], lfsr_state[0]};
    end
  endtask

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on the first failed check");
  endtask

  task automatic check_vec(input string what, input bus_vec_t got, input bus_vec_t exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_idx(input string what, input bus_idx_t got, input bus_idx_t exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_addr(input string what, input prog_addr_t got, input prog_addr_t exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp)
      fail_run($sformatf("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  // Samples the outputs of the cycle that just ended, then drives the next one
  task automatic tick();
    delivery_t rec;
    word_t     w;
    @(posedge clk);
    cycle_no++;
    s_ready      = cmd_ready;
    s_enables    = sender_enables;
    s_acks       = receiver_send_acks;
    s_active     = interrupt_active;
    s_irq_valid  = irq_valid;
    s_recv_valid = recv_valid;
    if (irq_valid === 1'b1) begin
      rec = '{EXP_IRQ, irq_bus, irq_address, irq_value, receiver_send_acks, cycle_no};
      seen.push_back(rec);
    end
    if (recv_valid === 1'b1) begin
      rec = '{EXP_RECV, recv_bus, '0, recv_value, receiver_send_acks, cycle_no};
      seen.push_back(rec);
    end
    // Each sender drops its send on the edge after its acknowledge
    receiver_sends <= (receiver_sends & ~receiver_send_acks) | raise_pending;
    for (int i = 0; i < BUS_COUNT; i++) begin
      if (raise_pending[i]) begin
        draw_word(w);
        data_model[i] = w;
        receiver_datas[i] <= w;
      end
    end
    if (raise_pending != '0)
      raise_cycle = cycle_no;
    raise_pending = '0;
  endtask

  function automatic bus_vec_t next_selection(input bus_vec_t cur, input uarc_op_e op,
                                              input bus_idx_t bus);
    bus_vec_t sel;
    sel = cur;
    case (op)
      OP_SEB: begin
        sel = '0;
        sel[bus] = 1'b1;
      end
      OP_SLB:  sel[bus] = 1'b1;
      OP_USB:  sel[bus] = 1'b0;
      default: ;
    endcase
    return sel;
  endfunction

  task automatic run_command(input row_t row);
    int waited;
    cmd_valid        <= 1'b1;
    cmd_op           <= row.op;
    cmd_bus          <= row.bus;
    cmd_addr         <= row.addr;
    receiver_enables <= row.enables;
    if (row.op == OP_RECV) begin
      // Nothing selected is sending yet, so the host stays blocked
      repeat (3) begin
        tick();
        check_flag("cmd_ready during a blocked receive", s_ready, 1'b0);
      end
      raise_pending = row.raise;
    end
    waited = 0;
    do begin
      if (waited == WAIT_LIMIT)
        fail_run("Timeout: the command was never accepted by the DUT");
      tick();
      waited++;
    end while (s_ready !== 1'b1);
    cmd_valid <= 1'b0;
    cmd_op    <= OP_NOP;
    if (row.op == OP_RETI)
      active_model = 1'b0;
    sel_model = next_selection(sel_model, row.op, row.bus);
    tick();
    check_vec("sender_enables", s_enables, sel_model);
    if (row.op != OP_RECV)
      raise_pending = row.raise;
  endtask

  task automatic check_outcome(input row_t row);
    delivery_t rec;
    int        waited;
    if (row.kind != EXP_NONE) begin
      waited = 0;
      while (seen.size() == 0) begin
        if (waited == WAIT_LIMIT)
          fail_run("Timeout: the expected delivery never appeared");
        tick();
        waited++;
      end
      rec = seen.pop_front();
      check_flag("delivery is an interrupt", rec.kind == EXP_IRQ, row.kind == EXP_IRQ);
      check_idx("delivered bus", rec.bus, row.exp_bus);
      check_word("delivered data", rec.value, data_model[row.exp_bus]);
      check_vec("receiver_send_acks", rec.acks, bus_vec_t'(1) << row.exp_bus);
      if (row.kind == EXP_IRQ) begin
        check_addr("irq_address", rec.addr, row.exp_addr);
        active_model = 1'b1;
        if (row.raise != '0)
          check_count("cycles from send to interrupt", rec.cycle - raise_cycle, 2);
      end
    end
    repeat (SETTLE_CYCLES) tick();
    check_count("unexpected deliveries", seen.size(), 0);
    check_flag("interrupt_active", s_active, active_model);
  endtask

  task automatic add_row(input uarc_op_e op, input bus_idx_t bus, input prog_addr_t addr,
                         input bus_vec_t enables, input bus_vec_t raise,
                         input exp_kind_e kind, input bus_idx_t exp_bus,
                         input prog_addr_t exp_addr);
    stim_rows.push_back(row_t'{op, bus, addr, enables, raise, kind, exp_bus, exp_addr});
  endtask

  task automatic build_table();
    // Selection sequences
    add_row(OP_SEB,    3'd3, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_SLB,    3'd5, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_SLB,    3'd1, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_USB,    3'd3, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_USB,    3'd4, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    // A distinct entry address per bus, then enable buses 2, 5 and 6
    add_row(OP_SEB,    3'd2, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_INTSET, 3'd0, 12'h120, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_SEB,    3'd5, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_INTSET, 3'd0, 12'h250, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_SEB,    3'd6, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_INTSET, 3'd0, 12'h360, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_SLB,    3'd2, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_SLB,    3'd5, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_INTEN,  3'd0, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_SEB,    3'd1, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    // One interrupt, and a second send held back until RETI
    add_row(OP_NOP,    3'd0, 12'h000, 8'hff, 8'h20, EXP_IRQ,  3'd5, 12'h250);
    add_row(OP_NOP,    3'd0, 12'h000, 8'hff, 8'h04, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_RETI,   3'd0, 12'h000, 8'hff, 8'h00, EXP_IRQ,  3'd2, 12'h120);
    add_row(OP_RETI,   3'd0, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    // A send on a bus its sender holds disabled waits until it is enabled again
    add_row(OP_NOP,    3'd0, 12'h000, 8'hdf, 8'h20, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_NOP,    3'd0, 12'h000, 8'hff, 8'h00, EXP_IRQ,  3'd5, 12'h250);
    add_row(OP_RETI,   3'd0, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    // Two blocking receives where the second bus is also interrupt enabled
    add_row(OP_RECV,   3'd0, 12'h000, 8'hff, 8'h02, EXP_RECV, 3'd1, 12'h000);
    add_row(OP_SEB,    3'd6, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
    add_row(OP_RECV,   3'd0, 12'h000, 8'hff, 8'h40, EXP_RECV, 3'd6, 12'h000);
    // Three sends at once are served in ascending bus order
    add_row(OP_NOP,    3'd0, 12'h000, 8'hff, 8'h64, EXP_IRQ,  3'd2, 12'h120);
    add_row(OP_RETI,   3'd0, 12'h000, 8'hff, 8'h00, EXP_IRQ,  3'd5, 12'h250);
    add_row(OP_RETI,   3'd0, 12'h000, 8'hff, 8'h00, EXP_IRQ,  3'd6, 12'h360);
    add_row(OP_RETI,   3'd0, 12'h000, 8'hff, 8'h00, EXP_NONE, 3'd0, 12'h000);
  endtask

  initial begin
    row_t row;
    rst              = 1'b1;
    cmd_valid        = 1'b0;
    cmd_op           = OP_NOP;
    cmd_bus          = '0;
    cmd_addr         = '0;
    receiver_enables = '1;
    receiver_sends   = '0;
    receiver_datas   = '0;
    lfsr_state       = 16'd34;
    sel_model        = '0;
    active_model     = 1'b0;
    raise_pending    = '0;
    cycle_no         = 0;
    raise_cycle      = 0;
    build_table();
    repeat (5) tick();
    rst <= 1'b0;
    tick();
    check_vec("sender_enables after reset", s_enables, '0);
    check_vec("receiver_send_acks after reset", s_acks, '0);
    check_flag("irq_valid after reset", s_irq_valid, 1'b0);
    check_flag("recv_valid after reset", s_recv_valid, 1'b0);
    check_flag("interrupt_active after reset", s_active, 1'b0);
    check_flag("cmd_ready after reset", s_ready, 1'b1);
    check_count("deliveries during reset", seen.size(), 0);
    foreach (stim_rows[i]) begin
      row = stim_rows[i];
      run_command(row);
      check_outcome(row);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* test/uarc_intc_asserts.sv */
`timescale 1ns/1ps

module uarc_intc_asserts (
  input logic                   clk,
  input logic                   rst,
  input uarc_cfg_pkg::bus_vec_t irq_requests,
  input uarc_cfg_pkg::bus_vec_t recv_requests,
  input uarc_cfg_pkg::bus_vec_t receiver_send_acks,
  input logic                   irq_valid,
  input logic                   recv_valid
);

  // At most one bus is acknowledged in any cycle
  ack_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(receiver_send_acks))
    else $error("more than one bus acknowledged in one cycle");

  // A winner is delivered either as an interrupt or as a receive
  delivery_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(irq_valid && recv_valid))
    else $error("interrupt and receive delivered in the same cycle");

  // Every acknowledged bus was requesting on the edge before
  ack_had_send: assert property (@(posedge clk) disable iff (rst)
    (receiver_send_acks != '0) |->
      ((receiver_send_acks & ~$past(irq_requests | recv_requests)) == '0))
    else $error("acknowledge given to a bus that was not sending");

endmodule

bind uarc_irq_arbiter uarc_intc_asserts u_asserts (
  .clk                (clk),
  .rst                (rst),
  .irq_requests       (irq_requests),
  .recv_requests      (recv_requests),
  .receiver_send_acks (receiver_send_acks),
  .irq_valid          (irq_valid),
  .recv_valid         (recv_valid)
);

/* hw/uarc_intc.sv */
`timescale 1ns/1ps

module uarc_intc (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cmd_valid,
  input  uarc_isa_pkg::uarc_op_e   cmd_op,
  input  uarc_cfg_pkg::bus_idx_t   cmd_bus,
  input  uarc_cfg_pkg::prog_addr_t cmd_addr,
  input  uarc_cfg_pkg::bus_vec_t   receiver_enables,
  input  uarc_cfg_pkg::bus_vec_t   receiver_sends,
  input  uarc_cfg_pkg::word_t      [uarc_cfg_pkg::BUS_COUNT-1:0] receiver_datas,
  output logic                     cmd_ready,
  output uarc_cfg_pkg::bus_vec_t   sender_enables,
  output uarc_cfg_pkg::bus_vec_t   receiver_send_acks,
  output logic                     irq_valid,
  output uarc_cfg_pkg::bus_idx_t   irq_bus,
  output uarc_cfg_pkg::prog_addr_t irq_address,
  output uarc_cfg_pkg::word_t      irq_value,
  output logic                     recv_valid,
  output uarc_cfg_pkg::bus_idx_t   recv_bus,
  output uarc_cfg_pkg::word_t      recv_value,
  output logic                     interrupt_active
);
  import uarc_cfg_pkg::*;

  bus_vec_t   sel_load;
  bus_vec_t   sel_value;
  logic       ien_copy;
  logic       addr_load;
  prog_addr_t addr_value;
  logic       recv_req;
  logic       irq_return;
  logic       recv_grant;
  bus_vec_t   irq_requests;
  bus_vec_t   recv_requests;
  prog_addr_t [BUS_COUNT-1:0] entry_addresses;

  uarc_cmd_decode u_decode (
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_bus    (cmd_bus),
    .cmd_addr   (cmd_addr),
    .recv_grant (recv_grant),
    .cmd_ready  (cmd_ready),
    .sel_load   (sel_load),
    .sel_value  (sel_value),
    .ien_copy   (ien_copy),
    .addr_load  (addr_load),
    .addr_value (addr_value),
    .recv_req   (recv_req),
    .irq_return (irq_return)
  );

  // Sender enables follow the selection bits directly
  for (genvar i = 0; i < BUS_COUNT; i++) begin : g_slot
    uarc_bus_slot u_slot (
      .clk             (clk),
      .rst             (rst),
      .sel_load        (sel_load[i]),
      .sel_value       (sel_value[i]),
      .ien_copy        (ien_copy),
      .addr_load       (addr_load),
      .addr_value      (addr_value),
      .receiver_enable (receiver_enables[i]),
      .receiver_send   (receiver_sends[i]),
      .selected        (sender_enables[i]),
      .irq_request     (irq_requests[i]),
      .recv_request    (recv_requests[i]),
      .entry_address   (entry_addresses[i])
    );
  end

  uarc_irq_arbiter u_arbiter (
    .clk                (clk),
    .rst                (rst),
    .irq_requests       (irq_requests),
    .recv_requests      (recv_requests),
    .entry_addresses    (entry_addresses),
    .receiver_datas     (receiver_datas),
    .recv_req           (recv_req),
    .irq_return         (irq_return),
    .recv_grant         (recv_grant),
    .receiver_send_acks (receiver_send_acks),
    .irq_valid          (irq_valid),
    .irq_bus            (irq_bus),
    .irq_address        (irq_address),
    .irq_value          (irq_value),
    .recv_valid         (recv_valid),
    .recv_bus           (recv_bus),
    .recv_value         (recv_value),
    .interrupt_active   (interrupt_active)
  );

endmodule

/* hw/uarc_irq_arbiter.sv */
`timescale 1ns/1ps

module uarc_irq_arbiter (
  input  logic                     clk,
  input  logic                     rst,
  input  uarc_cfg_pkg::bus_vec_t   irq_requests,
  input  uarc_cfg_pkg::bus_vec_t   recv_requests,
  input  uarc_cfg_pkg::prog_addr_t [uarc_cfg_pkg::BUS_COUNT-1:0] entry_addresses,
  input  uarc_cfg_pkg::word_t      [uarc_cfg_pkg::BUS_COUNT-1:0] receiver_datas,
  input  logic                     recv_req,
  input  logic                     irq_return,
  output logic                     recv_grant,
  output uarc_cfg_pkg::bus_vec_t   receiver_send_acks,
  output logic                     irq_valid,
  output uarc_cfg_pkg::bus_idx_t   irq_bus,
  output uarc_cfg_pkg::prog_addr_t irq_address,
  output uarc_cfg_pkg::word_t      irq_value,
  output logic                     recv_valid,
  output uarc_cfg_pkg::bus_idx_t   recv_bus,
  output uarc_cfg_pkg::word_t      recv_value,
  output logic                     interrupt_active
);
  import uarc_cfg_pkg::*;

  bus_vec_t candidates;
  bus_idx_t pick_bus;
  logic     pick_found;
  logic     take_irq;

  // The sender still shows its send in the cycle its acknowledge is
  // high, so the bus acknowledged last edge must not win again
  always_comb begin
    if (recv_req) begin
      candidates = recv_requests & ~receiver_send_acks;
    end else if (!interrupt_active) begin
      candidates = irq_requests & ~receiver_send_acks;
    end else begin
      candidates = '0;
    end
  end

  // Lowest index wins, so scan downwards and let later hits overwrite
  always_comb begin
    pick_bus   = '0;
    pick_found = 1'b0;
    for (int i = BUS_COUNT - 1; i >= 0; i--) begin
      if (candidates[i]) begin
        pick_bus   = bus_idx_t'(i);
        pick_found = 1'b1;
      end
    end
  end

  assign recv_grant = recv_req && pick_found;
  assign take_irq   = pick_found && !recv_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      receiver_send_acks <= '0;
      irq_valid          <= 1'b0;
      recv_valid         <= 1'b0;
      interrupt_active   <= 1'b0;
    end else begin
      receiver_send_acks <= pick_found ? (bus_vec_t'(1) << pick_bus) : '0;
      irq_valid          <= take_irq;
      recv_valid         <= recv_grant;
      // An interrupt can only be taken while inactive, so the two
      // branches never fight over the same edge in practice
      if (take_irq) begin
        interrupt_active <= 1'b1;
      end else if (irq_return) begin
        interrupt_active <= 1'b0;
      end
    end
  end

  // Delivery payload is held until the next winner of the same kind
  always_ff @(posedge clk) begin
    if (take_irq) begin
      irq_bus     <= pick_bus;
      irq_address <= entry_addresses[pick_bus];
      irq_value   <= receiver_datas[pick_bus];
    end
    if (recv_grant) begin
      recv_bus   <= pick_bus;
      recv_value <= receiver_datas[pick_bus];
    end
  end

endmodule

/* hw/uarc_bus_slot.sv */
`timescale 1ns/1ps

module uarc_bus_slot (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     sel_load,
  input  logic                     sel_value,
  input  logic                     ien_copy,
  input  logic                     addr_load,
  input  uarc_cfg_pkg::prog_addr_t addr_value,
  input  logic                     receiver_enable,
  input  logic                     receiver_send,
  output logic                     selected,
  output logic                     irq_request,
  output logic                     recv_request,
  output uarc_cfg_pkg::prog_addr_t entry_address
);

  logic irq_enable;
  logic send_live;

  always_ff @(posedge clk) begin
    if (rst) begin
      selected      <= 1'b0;
      irq_enable    <= 1'b0;
      entry_address <= '0;
    end else begin
      if (sel_load) begin
        selected <= sel_value;
      end
      // Enables take a snapshot of the selection at the time of INTEN
      if (ien_copy) begin
        irq_enable <= selected;
      end
      if (addr_load && selected) begin
        entry_address <= addr_value;
      end
    end
  end

  // A send only counts while the sender side holds the bus enabled
  assign send_live = receiver_enable && receiver_send;

  assign irq_request  = send_live && irq_enable;
  assign recv_request = send_live && selected;

endmodule

/* hw/uarc_cmd_decode.sv */
`timescale 1ns/1ps

module uarc_cmd_decode (
  input  logic                     cmd_valid,
  input  uarc_isa_pkg::uarc_op_e   cmd_op,
  input  uarc_cfg_pkg::bus_idx_t   cmd_bus,
  input  uarc_cfg_pkg::prog_addr_t cmd_addr,
  input  logic                     recv_grant,
  output logic                     cmd_ready,
  output uarc_cfg_pkg::bus_vec_t   sel_load,
  output uarc_cfg_pkg::bus_vec_t   sel_value,
  output logic                     ien_copy,
  output logic                     addr_load,
  output uarc_cfg_pkg::prog_addr_t addr_value,
  output logic                     recv_req,
  output logic                     irq_return
);
  import uarc_cfg_pkg::*;
  import uarc_isa_pkg::*;

  logic     cmd_accept;
  bus_vec_t bus_onehot;

  // A receive is requested as soon as it is presented, independent of
  // cmd_ready, so the arbiter can answer within the same cycle
  assign recv_req = cmd_valid && (cmd_op == OP_RECV);

  // Only a pending receive without a winner stalls the host
  assign cmd_ready = !recv_req || recv_grant;

  assign cmd_accept = cmd_valid && cmd_ready;

  // The address is broadcast, each slot decides whether to take it
  assign addr_value = cmd_addr;

  always_comb begin
    bus_onehot = '0;
    bus_onehot[cmd_bus] = 1'b1;

    sel_load   = '0;
    sel_value  = '0;
    ien_copy   = 1'b0;
    addr_load  = 1'b0;
    irq_return = 1'b0;

    if (cmd_accept) begin
      case (cmd_op)
        // Exact select rewrites every bus, leaving only cmd_bus set
        OP_SEB: begin
          sel_load  = '1;
          sel_value = bus_onehot;
        end
        OP_SLB: begin
          sel_load  = bus_onehot;
          sel_value = bus_onehot;
        end
        // Unselect writes a zero into cmd_bus alone
        OP_USB: begin
          sel_load = bus_onehot;
        end
        OP_INTEN:  ien_copy = 1'b1;
        OP_INTSET: addr_load = 1'b1;
        OP_RETI:   irq_return = 1'b1;
        default: ;
      endcase
    end
  end

endmodule

/* hw/uarc_isa_pkg.sv */
package uarc_isa_pkg;

  // Bus commands the core can issue to the receiver logic.
  // SEB selects one bus only, SLB adds a bus, USB removes one.
  // INTEN copies the selection into the interrupt enables and
  // INTSET writes the entry address of every selected bus.
  // RECV blocks until a selected bus sends, RETI ends an interrupt
  typedef enum logic [3:0] {
    OP_NOP    = 4'h0,
    OP_SEB    = 4'h1,
    OP_SLB    = 4'h2,
    OP_USB    = 4'h3,
    OP_INTEN  = 4'h4,
    OP_INTSET = 4'h5,
    OP_RECV   = 4'h6,
    OP_RETI   = 4'h7
  } uarc_op_e;

endpackage

/* hw/uarc_cfg_pkg.sv */
package uarc_cfg_pkg;

  // Width of one data word carried on a bus
  localparam int WORD_WIDTH = 32;

  // Number of receive buses attached to this controller
  localparam int BUS_COUNT = 8;

  // Enough bits to name any one bus
  localparam int BUS_IDX_WIDTH = $clog2(BUS_COUNT);

  // Width of an interrupt entry address in program memory
  localparam int PROG_ADDR_WIDTH = 12;

  // One data word as delivered by a sender
  typedef logic [WORD_WIDTH-1:0] word_t;

  // Index of a single bus
  typedef logic [BUS_IDX_WIDTH-1:0] bus_idx_t;

  // Program address that an interrupt jumps to
  typedef logic [PROG_ADDR_WIDTH-1:0] prog_addr_t;

  // One bit per bus where bit i belongs to bus i
  typedef logic [BUS_COUNT-1:0] bus_vec_t;

endpackage
